// File: hw/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

  // horizontal timing in pixels
  localparam int h_visible = 16;
  localparam int h_front = 2;
  localparam int h_sync = 3;
  localparam int h_back = 3;
  localparam int h_total = h_visible + h_front + h_sync + h_back;

  // vertical timing in lines
  localparam int v_visible = 12;
  localparam int v_front = 1;
  localparam int v_sync = 2;
  localparam int v_back = 1;
  localparam int v_total = v_visible + v_front + v_sync + v_back;

  localparam int x_bits = 5;
  localparam int y_bits = 4;
  localparam int addr_bits = 8;
  localparam int data_bits = 16;
  localparam int color_bits = 4;
  localparam int pixel_bits = 3 * color_bits;

  // output fifo sizing
  localparam int fifo_depth = 16;
  localparam int fifo_ptr_bits = 4;
  localparam int fifo_almost_full_level = 12;

  typedef struct packed {
    logic [color_bits-1:0] pad;
    logic [color_bits-1:0] red;
    logic [color_bits-1:0] grn;
    logic [color_bits-1:0] blu;
  } pixel_color_t;

  // raw sram word, or the same bits as color channels
  typedef union packed {
    logic [data_bits-1:0] raw;
    pixel_color_t         color;
  } pixel_word_t;

  // row-major frame buffer address
  function automatic logic [addr_bits-1:0] fb_addr(input logic [x_bits-1:0] x,
                                                   input logic [y_bits-1:0] y);
    return addr_bits'(y) * addr_bits'(h_visible) + addr_bits'(x);
  endfunction

endpackage

`default_nettype wire

// File: hw/sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                wr_req,
  input  logic [gfx_pkg::addr_bits-1:0]       wr_addr,
  input  gfx_pkg::pixel_word_t                wr_data,
  output logic                                wr_grant,
  input  logic                                rd_req,
  input  logic [gfx_pkg::addr_bits-1:0]       rd_addr,
  output gfx_pkg::pixel_word_t                rd_data,
  output logic                                rd_valid,
  output logic [gfx_pkg::addr_bits-1:0]       sram_addr,
  output logic [gfx_pkg::data_bits-1:0]       sram_wdata,
  input  logic [gfx_pkg::data_bits-1:0]       sram_rdata,
  output logic                                sram_we_n,
  output logic                                sram_oe_n,
  output logic                                sram_ce_n
);

  // read cycle currently on the pins
  logic rd_pending;

  // reads always win
  assign wr_grant = wr_req & ~rd_req;

  // pin control
  always_ff @(posedge clk) begin
    if (reset) begin
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_ce_n <= 1'b1;
      rd_pending <= 1'b0;
    end else begin
      sram_ce_n <= ~(rd_req | wr_req);
      sram_oe_n <= ~rd_req;
      sram_we_n <= ~wr_grant;
      rd_pending <= rd_req;
    end
  end

  // address and write data
  always_ff @(posedge clk) begin
    if (rd_req) begin
      sram_addr <= rd_addr;
    end else if (wr_req) begin
      sram_addr <= wr_addr;
      sram_wdata <= wr_data.raw;
    end
  end

  // sample the data bus at the end of the read cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_pending;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pending) begin
      rd_data.raw <= sram_rdata;
    end
  end

endmodule

`default_nettype wire

// File: hw/fb_writer.sv
`timescale 1ns/1ps
`default_nettype none

module fb_writer (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [gfx_pkg::x_bits-1:0]     gfx_x,
  input  logic [gfx_pkg::y_bits-1:0]     gfx_y,
  input  logic [gfx_pkg::pixel_bits-1:0] gfx_color,
  input  logic                           gfx_valid,
  output logic                           gfx_ready,
  output logic                           wr_req,
  output logic [gfx_pkg::addr_bits-1:0]  wr_addr,
  output gfx_pkg::pixel_word_t           wr_data,
  input  logic                           wr_grant
);
  import gfx_pkg::*;

  logic accept;

  // free when idle, or when the pending write goes out this cycle
  assign gfx_ready = ~wr_req | wr_grant;
  assign accept = gfx_valid & gfx_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_req <= 1'b0;
    end else if (accept) begin
      wr_req <= 1'b1;
    end else if (wr_grant) begin
      wr_req <= 1'b0;
    end
  end

  // capture address and color on each transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr <= fb_addr(gfx_x, gfx_y);
      wr_data.color.pad <= '0;
      wr_data.color.red <= gfx_color[3*color_bits-1:2*color_bits];
      wr_data.color.grn <= gfx_color[2*color_bits-1:color_bits];
      wr_data.color.blu <= gfx_color[color_bits-1:0];
    end
  end

endmodule

`default_nettype wire

// File: hw/fb_pixel_stream.sv
`timescale 1ns/1ps
`default_nettype none

module fb_pixel_stream (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           enable,
  output logic                           rd_req,
  output logic [gfx_pkg::addr_bits-1:0]  rd_addr,
  input  gfx_pkg::pixel_word_t           rd_data,
  input  logic                           rd_valid,
  output logic                           push,
  output logic                           push_hsync,
  output logic                           push_vsync,
  output logic [gfx_pkg::pixel_bits-1:0] push_color
);
  import gfx_pkg::*;

  logic [x_bits-1:0] x_pos;
  logic [y_bits-1:0] y_pos;
  logic              visible;
  logic              hsync_n;
  logic              vsync_n;

  // two stages matching the read latency
  logic valid_s1;
  logic valid_s2;
  logic vis_s1;
  logic vis_s2;
  logic hsync_s1;
  logic vsync_s1;

  assign visible = (x_pos < x_bits'(h_visible)) && (y_pos < y_bits'(v_visible));

  // active low sync windows
  assign hsync_n = ~((x_pos >= x_bits'(h_visible + h_front)) &&
                     (x_pos < x_bits'(h_visible + h_front + h_sync)));
  assign vsync_n = ~((y_pos >= y_bits'(v_visible + v_front)) &&
                     (y_pos < y_bits'(v_visible + v_front + v_sync)));

  assign rd_req = enable & visible;
  assign rd_addr = fb_addr(x_pos, y_pos);

  // raster position
  always_ff @(posedge clk) begin
    if (reset) begin
      x_pos <= '0;
      y_pos <= '0;
    end else if (enable) begin
      if (x_pos == x_bits'(h_total - 1)) begin
        x_pos <= '0;
        if (y_pos == y_bits'(v_total - 1)) begin
          y_pos <= '0;
        end else begin
          y_pos <= y_pos + 1'b1;
        end
      end else begin
        x_pos <= x_pos + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= enable;
      valid_s2 <= valid_s1;
    end
  end

  // position attributes follow the valid bits
  always_ff @(posedge clk) begin
    vis_s1 <= visible;
    hsync_s1 <= hsync_n;
    vsync_s1 <= vsync_n;
    vis_s2 <= vis_s1;
    push_hsync <= hsync_s1;
    push_vsync <= vsync_s1;
  end

  assign push = valid_s2;
  // blanking positions carry black
  assign push_color = (vis_s2 && rd_valid) ?
                      {rd_data.color.red, rd_data.color.grn, rd_data.color.blu} : '0;

endmodule

`default_nettype wire

// File: hw/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           push,
  input  logic                           push_hsync,
  input  logic                           push_vsync,
  input  logic [gfx_pkg::pixel_bits-1:0] push_color,
  output logic                           almost_full,
  input  logic                           pixel_tick,
  output logic [gfx_pkg::color_bits-1:0] vga_red,
  output logic [gfx_pkg::color_bits-1:0] vga_grn,
  output logic [gfx_pkg::color_bits-1:0] vga_blu,
  output logic                           vga_hsync,
  output logic                           vga_vsync
);
  import gfx_pkg::*;

  // entry is {hsync, vsync, color}
  logic [pixel_bits+1:0]    mem [fifo_depth];
  logic [fifo_ptr_bits-1:0] wr_ptr;
  logic [fifo_ptr_bits-1:0] rd_ptr;
  logic [fifo_ptr_bits:0]   count;
  logic                     do_push;
  logic                     do_pop;

  assign do_push = push && (count != (fifo_ptr_bits + 1)'(fifo_depth));
  assign do_pop = pixel_tick && (count != '0);
  assign almost_full = count >= (fifo_ptr_bits + 1)'(fifo_almost_full_level);

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= {push_hsync, push_vsync, push_color};
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      wr_ptr <= wr_ptr + fifo_ptr_bits'(do_push);
      rd_ptr <= rd_ptr + fifo_ptr_bits'(do_pop);
      count <= count + (fifo_ptr_bits + 1)'(do_push) - (fifo_ptr_bits + 1)'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      {vga_hsync, vga_vsync, vga_red, vga_grn, vga_blu} <= {2'b11, pixel_bits'(0)};
    end else if (do_pop) begin
      {vga_hsync, vga_vsync, vga_red, vga_grn, vga_blu} <= mem[rd_ptr];
    end else if (pixel_tick) begin
      // underrun shows black, syncs idle
      {vga_hsync, vga_vsync, vga_red, vga_grn, vga_blu} <= {2'b11, pixel_bits'(0)};
    end
  end

endmodule

`default_nettype wire

// File: hw/gfx_vga.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_vga (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [gfx_pkg::x_bits-1:0]     gfx_x,
  input  logic [gfx_pkg::y_bits-1:0]     gfx_y,
  input  logic [gfx_pkg::pixel_bits-1:0] gfx_color,
  input  logic                           gfx_valid,
  output logic                           gfx_ready,
  input  logic                           pixel_tick,
  output logic [gfx_pkg::color_bits-1:0] vga_red,
  output logic [gfx_pkg::color_bits-1:0] vga_grn,
  output logic [gfx_pkg::color_bits-1:0] vga_blu,
  output logic                           vga_hsync,
  output logic                           vga_vsync,
  output logic [gfx_pkg::addr_bits-1:0]  sram_addr,
  output logic [gfx_pkg::data_bits-1:0]  sram_wdata,
  input  logic [gfx_pkg::data_bits-1:0]  sram_rdata,
  output logic                           sram_we_n,
  output logic                           sram_oe_n,
  output logic                           sram_ce_n
);
  import gfx_pkg::*;

  // writer side
  logic                 wr_req;
  logic                 wr_grant;
  logic [addr_bits-1:0] wr_addr;
  pixel_word_t          wr_data;

  // display side
  logic                  rd_req;
  logic                  rd_valid;
  logic [addr_bits-1:0]  rd_addr;
  pixel_word_t           rd_data;
  logic                  push;
  logic                  push_hsync;
  logic                  push_vsync;
  logic [pixel_bits-1:0] push_color;
  logic                  almost_full;
  logic                  stream_enable;

  // hold the raster while the fifo is nearly full
  assign stream_enable = ~almost_full;

  sram_arbiter sram_arbiter_i (
    .clk(clk), .reset(reset),
    .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_grant(wr_grant),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_data(rd_data), .rd_valid(rd_valid),
    .sram_addr(sram_addr), .sram_wdata(sram_wdata), .sram_rdata(sram_rdata),
    .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n), .sram_ce_n(sram_ce_n)
  );

  fb_writer fb_writer_i (
    .clk(clk), .reset(reset),
    .gfx_x(gfx_x), .gfx_y(gfx_y), .gfx_color(gfx_color),
    .gfx_valid(gfx_valid), .gfx_ready(gfx_ready),
    .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_grant(wr_grant)
  );

  fb_pixel_stream fb_pixel_stream_i (
    .clk(clk), .reset(reset), .enable(stream_enable),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_data(rd_data), .rd_valid(rd_valid),
    .push(push), .push_hsync(push_hsync), .push_vsync(push_vsync),
    .push_color(push_color)
  );

  pixel_fifo pixel_fifo_i (
    .clk(clk), .reset(reset),
    .push(push), .push_hsync(push_hsync), .push_vsync(push_vsync),
    .push_color(push_color), .almost_full(almost_full), .pixel_tick(pixel_tick),
    .vga_red(vga_red), .vga_grn(vga_grn), .vga_blu(vga_blu),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

endmodule

`default_nettype wire

// File: verification/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model (
  input  logic                          clk,
  input  logic [gfx_pkg::addr_bits-1:0] addr,
  input  logic [gfx_pkg::data_bits-1:0] wdata,
  output logic [gfx_pkg::data_bits-1:0] rdata,
  input  logic                          we_n,
  input  logic                          oe_n,
  input  logic                          ce_n
);
  import gfx_pkg::*;

  logic [data_bits-1:0] mem [2**addr_bits];

  // power-up contents follow the address
  initial begin
    for (int i = 0; i < 2**addr_bits; i++) begin
      mem[i] = {addr_bits'(i), ~addr_bits'(i)};
    end
  end

  // asynchronous read while selected
  assign rdata = (!ce_n && !oe_n) ? mem[addr] : '0;

  always @(posedge clk) begin
    if (!ce_n && !we_n) begin
      mem[addr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: verification/gfx_vga_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_vga_tb;
  import gfx_pkg::*;

  localparam int tick_period = 4;
  localparam int frame_samples = h_total * v_total;
  localparam int frame_cycles = frame_samples * tick_period;
  // eight frames plus the single pixel writes
  localparam int timeout_cycles = 8 * frame_cycles + 40 * h_visible * v_visible;

  logic                  clk;
  logic                  reset;
  logic [x_bits-1:0]     gfx_x;
  logic [y_bits-1:0]     gfx_y;
  logic [pixel_bits-1:0] gfx_color;
  logic                  gfx_valid;
  logic                  gfx_ready;
  logic                  pixel_tick = 1'b0;
  logic [color_bits-1:0] vga_red;
  logic [color_bits-1:0] vga_grn;
  logic [color_bits-1:0] vga_blu;
  logic                  vga_hsync;
  logic                  vga_vsync;
  logic [addr_bits-1:0]  sram_addr;
  logic [data_bits-1:0]  sram_wdata;
  logic [data_bits-1:0]  sram_rdata;
  logic                  sram_we_n;
  logic                  sram_oe_n;
  logic                  sram_ce_n;

  logic                  tick_pause = 1'b0;
  logic                  tick_on = 1'b0;
  int                    tick_cnt = 0;
  int                    cycle_count = 0;
  int                    errors = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;

  // expected frame buffer and the last captured frame
  logic [pixel_bits-1:0] ref_color [v_visible][h_visible];
  logic                  cap_hs [frame_samples];
  logic                  cap_vs [frame_samples];
  logic [pixel_bits-1:0] cap_color [frame_samples];

  gfx_vga gfx_vga_i (
    .clk(clk), .reset(reset),
    .gfx_x(gfx_x), .gfx_y(gfx_y), .gfx_color(gfx_color),
    .gfx_valid(gfx_valid), .gfx_ready(gfx_ready), .pixel_tick(pixel_tick),
    .vga_red(vga_red), .vga_grn(vga_grn), .vga_blu(vga_blu),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync),
    .sram_addr(sram_addr), .sram_wdata(sram_wdata), .sram_rdata(sram_rdata),
    .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n), .sram_ce_n(sram_ce_n)
  );

  sram_model sram_model_i (
    .clk(clk), .addr(sram_addr), .wdata(sram_wdata), .rdata(sram_rdata),
    .we_n(sram_we_n), .oe_n(sram_oe_n), .ce_n(sram_ce_n)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one pixel strobe every tick_period cycles
  always @(posedge clk) begin
    tick_on = !reset && !tick_pause;
    #1;
    tick_cnt = tick_on ? (tick_cnt + 1) % tick_period : 0;
    pixel_tick = tick_on && (tick_cnt == 0);
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic report_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
      $display("test %-20s passed", name);
    end else begin
      tests_failed++;
      $display("test %-20s failed with %0d errors", name, errors - start);
    end
  endtask

  task automatic write_pixel(input int x, input int y, input logic [pixel_bits-1:0] color);
    int          waited;
    logic [15:0] word;
    @(posedge clk);
    #1;
    gfx_x = x_bits'(x);
    gfx_y = y_bits'(y);
    gfx_color = color;
    gfx_valid = 1'b1;
    @(negedge clk);
    while (!gfx_ready) @(negedge clk);
    // transfer on this edge
    @(posedge clk);
    #1;
    gfx_valid = 1'b0;
    ref_color[y][x] = color;
    waited = 0;
    @(negedge clk);
    while (!gfx_ready && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (!gfx_ready) begin
      errors++;
      $display("gfx_ready stayed low after the write to (%0d,%0d)", x, y);
    end
    // grant, then pins, then the array holds the word
    repeat (2) @(posedge clk);
    #1;
    word = sram_model_i.mem[y * h_visible + x];
    if (word !== {4'h0, color}) begin
      errors++;
      $display("Mismatch at %0t: sram word for (%0d,%0d) is %h, expected %h",
               $time, x, y, word, {4'h0, color});
    end
  endtask

  // starts at the first output sample with vsync low
  task automatic capture_frame();
    @(negedge clk);
    while (!vga_vsync) @(negedge clk);
    while (vga_vsync) @(negedge clk);
    for (int k = 0; k < frame_samples; k++) begin
      if (k > 0) begin
        @(negedge clk);
        while (!pixel_tick) @(negedge clk);
        @(negedge clk);
      end
      cap_hs[k] = vga_hsync;
      cap_vs[k] = vga_vsync;
      cap_color[k] = {vga_red, vga_grn, vga_blu};
    end
  endtask

  task automatic check_frame(input bit with_colors);
    int                    x;
    int                    y;
    int                    row;
    logic                  exp_hs;
    logic                  exp_vs;
    logic [pixel_bits-1:0] exp_color;
    for (int k = 0; k < frame_samples; k++) begin
      x = k % h_total;
      row = k / h_total;
      // capture opens with the sync lines, then back porch, visible lines and front porch
      y = (row + v_total - v_sync - v_back) % v_total;
      exp_hs = !(x >= h_total - h_back - h_sync && x < h_total - h_back);
      exp_vs = row >= v_sync;
      exp_color = '0;
      if (x < h_visible && y < v_visible) begin
        exp_color = ref_color[y][x];
      end
      if (cap_hs[k] !== exp_hs || cap_vs[k] !== exp_vs) begin
        errors++;
        $display("Mismatch at %0t: syncs at (%0d,%0d) are %b%b, expected %b%b",
                 $time, x, y, cap_hs[k], cap_vs[k], exp_hs, exp_vs);
      end
      if (with_colors && cap_color[k] !== exp_color) begin
        errors++;
        $display("Mismatch at %0t: color at (%0d,%0d) is %h, expected %h",
                 $time, x, y, cap_color[k], exp_color);
      end
    end
  endtask

  // sampled in the last reset cycle
  task automatic reset_values();
    int start;
    start = errors;
    @(negedge clk);
    if (gfx_ready !== 1'b1) begin
      errors++;
      $display("Mismatch at %0t: gfx_ready is %b in reset", $time, gfx_ready);
    end
    if ({sram_we_n, sram_oe_n, sram_ce_n} !== 3'b111) begin
      errors++;
      $display("Mismatch at %0t: sram controls are %b%b%b in reset",
               $time, sram_we_n, sram_oe_n, sram_ce_n);
    end
    if ({vga_hsync, vga_vsync} !== 2'b11 || {vga_red, vga_grn, vga_blu} !== '0) begin
      errors++;
      $display("Mismatch at %0t: vga outputs are %b%b %h in reset",
               $time, vga_hsync, vga_vsync, {vga_red, vga_grn, vga_blu});
    end
    report_test("reset values", start);
  endtask

  task automatic write_path();
    int start;
    start = errors;
    // the four corners, then a few anywhere
    write_pixel(0, 0, pixel_bits'($urandom));
    write_pixel(h_visible - 1, 0, pixel_bits'($urandom));
    write_pixel(0, v_visible - 1, pixel_bits'($urandom));
    write_pixel(h_visible - 1, v_visible - 1, pixel_bits'($urandom));
    for (int i = 0; i < 4; i++) begin
      write_pixel($urandom % h_visible, $urandom % v_visible, pixel_bits'($urandom));
    end
    report_test("write path", start);
  endtask

  task automatic sync_timing();
    int start;
    start = errors;
    capture_frame();
    check_frame(1'b0);
    report_test("sync timing", start);
  endtask

  task automatic display_contents();
    int start;
    start = errors;
    for (int y = 0; y < v_visible; y++) begin
      for (int x = 0; x < h_visible; x++) begin
        write_pixel(x, y, pixel_bits'($urandom));
      end
    end
    capture_frame();
    check_frame(1'b1);
    report_test("display contents", start);
  endtask

  task automatic writes_under_load();
    int start;
    start = errors;
    for (int i = 0; i < 32; i++) begin
      write_pixel($urandom % h_visible, $urandom % v_visible, pixel_bits'($urandom));
    end
    capture_frame();
    check_frame(1'b1);
    report_test("writes under load", start);
  endtask

  task automatic back_pressure();
    int start;
    start = errors;
    @(posedge clk);
    #1;
    tick_pause = 1'b1;
    repeat (200) @(posedge clk);
    @(negedge clk);
    // with the fifo full the streamer should have stopped reading
    if (sram_oe_n !== 1'b1) begin
      errors++;
      $display("Mismatch at %0t: sram_oe_n is %b with the display paused", $time, sram_oe_n);
    end
    @(posedge clk);
    #1;
    tick_pause = 1'b0;
    capture_frame();
    check_frame(1'b1);
    report_test("back pressure", start);
  endtask

  initial begin
    void'($urandom(32'h383c_53ae));
    reset = 1'b1;
    gfx_x = '0;
    gfx_y = '0;
    gfx_color = '0;
    gfx_valid = 1'b0;
    repeat (2) @(posedge clk);
    reset_values();
    @(posedge clk);
    #1;
    reset = 1'b0;
    write_path();
    sync_timing();
    display_contents();
    writes_under_load();
    back_pressure();
    $display("summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/gfx_pkg.sv
hw/sram_arbiter.sv
hw/fb_writer.sv
hw/fb_pixel_stream.sv
hw/pixel_fifo.sv
hw/gfx_vga.sv
verification/sram_model.sv
verification/gfx_vga_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = gfx_vga_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
